// File: all.f
source/cache_pkg.sv
source/plru_tree.sv
source/cache_mem.sv
source/victim_buffer.sv
source/writeback_drain.sv
source/cache_top.sv
dv/cache_assert.sv
dv/cache_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module cache_tb -f all.f -o cache_sim \
  && ./obj_dir/cache_sim | tee /dev/stderr | grep -qx "Finished with no errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: dv/cache_tb.sv
// cache_tb: directed and seeded random requests checked against a reference cache model
`timescale 1ns/1ns

module cache_tb;

  import cache_pkg::*;

  localparam int num_ways    = 4;
  localparam int vb_depth    = 4;
  localparam int drain_limit = 200;

  logic       clock;
  logic       reset;
  logic       req_valid;
  cache_req_t req;
  logic       rsp_valid;
  cache_rsp_t rsp;
  logic       mem_ready;
  logic       wb_valid;
  wb_t        wb;
  logic       vb_overflow;

  // reference model state
  logic                 m_valid [num_sets][num_ways];
  logic                 m_dirty [num_sets][num_ways];
  logic [tag_bits-1:0]  m_tag   [num_sets][num_ways];
  logic [data_bits-1:0] m_data  [num_sets][num_ways];
  logic [num_ways-2:0]  m_tree  [num_sets];
  victim_t              m_fifo  [$];
  logic                 m_pend_valid;
  victim_t              m_pend;
  logic                 m_overflow;
  logic                 exp_rsp_valid;
  cache_rsp_t           exp_rsp;
  logic                 exp_wb_valid;
  wb_t                  exp_wb;

  integer seed;
  int     check_errors;
  int     timeout_errors;
  string  phase;

  cache_top #(.num_ways(num_ways), .vb_depth(vb_depth)) dut_i (.*);

  always #10 clock = ~clock;

  // walk down from the root, right on a one
  function automatic int tree_victim(input logic [num_ways-2:0] t);
    int node;
    int way;
    node = 0;
    way = 0;
    while (node < num_ways - 1) begin
      way = 2 * way + (t[node] ? 1 : 0);
      node = 2 * node + (t[node] ? 2 : 1);
    end
    return way;
  endfunction

  // nodes on the path point to the other half
  function automatic logic [num_ways-2:0] tree_touch(input logic [num_ways-2:0] t, input int way);
    int node;
    int lo;
    int span;
    node = 0;
    lo = 0;
    span = num_ways;
    while (span > 1) begin
      span = span / 2;
      if (way < lo + span) begin
        t[node] = 1'b1;
        node = 2 * node + 1;
      end else begin
        t[node] = 1'b0;
        lo = lo + span;
        node = 2 * node + 2;
      end
    end
    return t;
  endfunction

  function automatic cache_req_t make_req(input cache_op_t op, input int idx, input int tag,
                                          input logic dirty);
    cache_req_t r;
    r.op    = op;
    r.idx   = set_bits'(idx);
    r.tag   = tag_bits'(tag);
    r.data  = {$random(seed), $random(seed)};
    r.dirty = dirty;
    return r;
  endfunction

  // small tag pool keeps hits and evictions frequent
  task automatic random_req(output logic v, output cache_req_t r);
    cache_op_t op;
    int        tag;
    op  = ($random(seed) & 1) ? op_write : op_read;
    v   = ($random(seed) & 7) != 0;
    tag = 'h040 + ({$random(seed)} % 6);
    r   = make_req(op, $random(seed) & 7, tag, ($random(seed) & 3) != 0);
  endtask

  task automatic model_reset();
    for (int s = 0; s < num_sets; s++) begin
      m_tree[s] = '0;
      for (int w = 0; w < num_ways; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = '0;
        m_data[s][w]  = '0;
      end
    end
    m_fifo.delete();
    m_pend_valid = 1'b0;
    m_overflow   = 1'b0;
  endtask

  // one clock edge of the model, using the inputs the DUT samples there
  task automatic model_edge();
    int      hw;
    int      vw;
    int      s;
    int      fill_count;
    victim_t front;
    fill_count   = m_fifo.size();
    exp_wb_valid = 1'b0;
    if (fill_count > 0 && (!m_fifo[0].line.dirty || mem_ready)) begin
      front = m_fifo.pop_front();
      if (front.line.dirty) begin
        exp_wb_valid = 1'b1;
        exp_wb.addr  = {front.line.tag, front.idx};
        exp_wb.data  = front.line.data;
      end
    end
    // victim of the previous request, lost when the buffer was full
    if (m_pend_valid) begin
      if (fill_count == vb_depth) begin
        m_overflow = 1'b1;
      end else begin
        m_fifo.push_back(m_pend);
      end
    end
    m_pend_valid  = 1'b0;
    exp_rsp_valid = req_valid;
    if (req_valid) begin
      s  = int'(req.idx);
      hw = -1;
      for (int w = 0; w < num_ways; w++) begin
        if (m_valid[s][w] && m_tag[s][w] == req.tag) begin
          hw = w;
        end
      end
      exp_rsp.hit  = (hw >= 0);
      exp_rsp.data = (hw >= 0) ? m_data[s][hw] : '0;
      if (hw >= 0) begin
        m_tree[s] = tree_touch(m_tree[s], hw);
        if (req.op == op_write) begin
          m_data[s][hw]  = req.data;
          m_dirty[s][hw] = req.dirty;
        end
      end else if (req.op == op_write) begin
        vw = tree_victim(m_tree[s]);
        if (m_valid[s][vw]) begin
          m_pend_valid     = 1'b1;
          m_pend.idx       = req.idx;
          m_pend.line      = {1'b1, m_dirty[s][vw], m_tag[s][vw], m_data[s][vw]};
        end
        m_valid[s][vw] = 1'b1;
        m_dirty[s][vw] = req.dirty;
        m_tag[s][vw]   = req.tag;
        m_data[s][vw]  = req.data;
        m_tree[s]      = tree_touch(m_tree[s], vw);
      end
    end
  endtask

  task automatic report_mismatch(input string what, input logic [79:0] expected,
                                 input logic [79:0] actual);
    check_errors++;
    $display("CHECK FAILED %s %s: expected %h, actual %h", phase, what, expected, actual);
  endtask

  task automatic check_outputs();
    if (rsp_valid !== exp_rsp_valid) begin
      report_mismatch("rsp_valid", 80'(exp_rsp_valid), 80'(rsp_valid));
    end else if (exp_rsp_valid && rsp !== exp_rsp) begin
      report_mismatch("rsp", 80'(exp_rsp), 80'(rsp));
    end
    if (wb_valid !== exp_wb_valid) begin
      report_mismatch("wb_valid", 80'(exp_wb_valid), 80'(wb_valid));
    end else if (exp_wb_valid && wb !== exp_wb) begin
      report_mismatch("wb", 80'(exp_wb), 80'(wb));
    end
    if (vb_overflow !== m_overflow) begin
      report_mismatch("vb_overflow", 80'(m_overflow), 80'(vb_overflow));
    end
  endtask

  // model and DUT share the edge, outputs are compared at the falling edge
  task automatic run_cycle(input logic v, input cache_req_t r, input logic ready);
    @(posedge clock);
    model_edge();
    req_valid <= v;
    req       <= r;
    mem_ready <= ready;
    @(negedge clock);
    check_outputs();
  endtask

  initial begin
    cache_req_t r;
    logic       v;
    int         waited;
    seed           = 12;
    clock          = 1'b0;
    reset          = 1'b1;
    req_valid      = 1'b0;
    req            = '0;
    mem_ready      = 1'b1;
    check_errors   = 0;
    timeout_errors = 0;
    phase          = "reset_reads";
    model_reset();
    repeat (8) @(posedge clock);
    reset <= 1'b0;

    for (int i = 0; i < num_sets; i++) begin
      run_cycle(1'b1, make_req(op_read, i, 'h040 + i, 1'b0), 1'b1);
    end

    phase = "write_read";
    run_cycle(1'b1, make_req(op_write, 2, 'h155, 1'b1), 1'b1);
    run_cycle(1'b1, make_req(op_read, 2, 'h155, 1'b0), 1'b1);
    run_cycle(1'b1, make_req(op_write, 2, 'h155, 1'b1), 1'b1);
    run_cycle(1'b1, make_req(op_read, 2, 'h155, 1'b0), 1'b1);

    // five tags into one set, a read hit shifts the order
    phase = "plru_order";
    for (int i = 0; i < 5; i++) begin
      run_cycle(1'b1, make_req(op_write, 5, 'h200 + i, 1'b1), 1'b1);
      if (i == 1) begin
        run_cycle(1'b1, make_req(op_read, 5, 'h200, 1'b0), 1'b1);
      end
    end
    run_cycle(1'b1, make_req(op_read, 5, 'h201, 1'b0), 1'b1);
    run_cycle(1'b1, make_req(op_write, 5, 'h205, 1'b0), 1'b1);

    phase = "random_mix";
    for (int i = 0; i < 400; i++) begin
      random_req(v, r);
      run_cycle(v, r, ($random(seed) & 3) != 0);
    end

    // memory stalled while dirty lines keep leaving one set
    phase = "overflow";
    for (int i = 0; i < 12; i++) begin
      run_cycle(1'b1, make_req(op_write, 6, 'h300 + i, 1'b1), 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      run_cycle(1'b0, '0, 1'b0);
    end
    // eight dirty evictions into a four entry buffer must overflow it
    if (vb_overflow !== 1'b1) begin
      report_mismatch("vb_overflow after stall", 80'(1'b1), 80'(vb_overflow));
    end

    phase  = "drain";
    waited = 0;
    while ((m_fifo.size() != 0 || m_pend_valid || wb_valid) && waited < drain_limit) begin
      run_cycle(1'b0, '0, 1'b1);
      waited++;
    end
    if (waited >= drain_limit) begin
      timeout_errors++;
      $display("timeout: victim buffer still holds lines after %0d cycles", drain_limit);
    end
    run_cycle(1'b0, '0, 1'b1);

    $display("errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: dv/cache_assert.sv
// cache_assert: protocol checks on the cache strobes and the victim buffer pop
`timescale 1ns/1ns

module cache_assert (
  input logic clock,
  input logic reset,
  input logic req_valid,
  input logic rsp_valid,
  input logic vic_valid,
  input logic wb_valid,
  input logic pop,
  input logic not_empty
);

  // fixed one cycle lookup latency
  rsp_follows_req: assert property (@(posedge clock) disable iff (reset)
    rsp_valid == $past(req_valid))
    else $error("rsp_valid does not follow req_valid by one cycle");

  wb_after_pop: assert property (@(posedge clock) disable iff (reset)
    wb_valid |-> $past(pop))
    else $error("wb_valid without a pop in the previous cycle");

  // an empty buffer only gains an entry from a victim push
  empty_until_push: assert property (@(posedge clock) disable iff (reset)
    !not_empty |=> (not_empty == $past(vic_valid)))
    else $error("victim buffer emptiness does not follow the victim push");

  // registered strobes settle low one edge into reset
  quiet_in_reset: assert property (@(posedge clock)
    reset |=> !(rsp_valid || vic_valid || wb_valid || pop))
    else $error("strobe high during reset");

endmodule

bind cache_top cache_assert assert_i (
  .clock     (clock),
  .reset     (reset),
  .req_valid (req_valid),
  .rsp_valid (rsp_valid),
  .vic_valid (vic_valid),
  .wb_valid  (wb_valid),
  .pop       (pop),
  .not_empty (not_empty)
);

// File: source/cache_top.sv
// cache_top: data cache array feeding evicted lines through a victim FIFO to the writeback drain
`timescale 1ns/1ns

module cache_top #(
  parameter int num_ways = 4,
  parameter int vb_depth = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  rsp_valid,
  output cache_pkg::cache_rsp_t rsp,
  input  logic                  mem_ready,
  output logic                  wb_valid,
  output cache_pkg::wb_t        wb,
  output logic                  vb_overflow
);

  import cache_pkg::*;

  logic    vic_valid;
  victim_t vic;
  victim_t head;
  logic    not_empty;
  logic    pop;

  cache_mem #(
    .num_ways (num_ways)
  ) cache_mem_i (
    .clock     (clock),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .vic_valid (vic_valid),
    .vic       (vic)
  );

  victim_buffer #(
    .vb_depth (vb_depth)
  ) victim_buffer_i (
    .clock     (clock),
    .reset     (reset),
    .push      (vic_valid),
    .push_data (vic),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .overflow  (vb_overflow)
  );

  writeback_drain writeback_drain_i (
    .clock     (clock),
    .reset     (reset),
    .head      (head),
    .not_empty (not_empty),
    .mem_ready (mem_ready),
    .pop       (pop),
    .wb_valid  (wb_valid),
    .wb        (wb)
  );

endmodule

// File: source/writeback_drain.sv
// writeback_drain: pops victims, sends dirty lines to memory and discards clean ones
`timescale 1ns/1ns

module writeback_drain (
  input  logic               clock,
  input  logic               reset,
  input  cache_pkg::victim_t head,
  input  logic               not_empty,
  input  logic               mem_ready,
  output logic               pop,
  output logic               wb_valid,
  output cache_pkg::wb_t     wb
);

  logic send;

  // clean victims leave without waiting for memory
  assign pop  = not_empty && (!head.line.dirty || mem_ready);
  assign send = pop && head.line.dirty;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= send;
    end
  end

  // rebuild the line address, tag above index
  always_ff @(posedge clock) begin
    if (send) begin
      wb.addr <= {head.line.tag, head.idx};
      wb.data <= head.line.data;
    end
  end

endmodule

// File: source/victim_buffer.sv
// victim_buffer: circular FIFO of evicted lines with a sticky overflow flag
`timescale 1ns/1ns

module victim_buffer #(
  parameter int vb_depth = 4
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               push,
  input  cache_pkg::victim_t push_data,
  input  logic               pop,
  output cache_pkg::victim_t head,
  output logic               not_empty,
  output logic               overflow
);

  import cache_pkg::*;

  localparam int ptr_bits = (vb_depth > 1) ? $clog2(vb_depth) : 1;
  localparam int cnt_bits = $clog2(vb_depth + 1);

  victim_t             mem [vb_depth];
  logic [ptr_bits-1:0] rd_ptr;
  logic [ptr_bits-1:0] wr_ptr;
  logic [cnt_bits-1:0] count;
  logic                full;
  logic                do_push;
  logic                do_pop;

  // wrap explicitly so any depth works
  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    if (ptr == ptr_bits'(vb_depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full      = (count == cnt_bits'(vb_depth));
  assign not_empty = (count != '0);
  // full drops the push even if the head leaves this cycle
  assign do_push   = push && !full;
  assign do_pop    = pop && not_empty;
  assign head      = mem[rd_ptr];

  always_ff @(posedge clock) begin
    if (reset) begin
      rd_ptr   <= '0;
      wr_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // sticky until reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

endmodule

// File: source/cache_mem.sv
// cache_mem: set-associative tag and data arrays with lookup, fill, eviction and PLRU state
`timescale 1ns/1ns

module cache_mem #(
  parameter int num_ways = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  req_valid,
  input  cache_pkg::cache_req_t req,
  output logic                  rsp_valid,
  output cache_pkg::cache_rsp_t rsp,
  output logic                  vic_valid,
  output cache_pkg::victim_t    vic
);

  import cache_pkg::*;

  localparam int way_bits = $clog2(num_ways);

  // per-way storage, only valid and tree bits are control state
  logic [tag_bits-1:0]  tag_q   [num_sets][num_ways];
  logic [data_bits-1:0] data_q  [num_sets][num_ways];
  logic                 dirty_q [num_sets][num_ways];
  logic [num_ways-1:0]  valid_q [num_sets];
  logic [num_ways-2:0]  plru_q  [num_sets];

  logic [num_ways-1:0] hit_vec;
  logic                hit;
  logic [way_bits-1:0] hit_way;
  logic [way_bits-1:0] victim_way;
  logic [way_bits-1:0] access_way;
  logic [num_ways-2:0] plru_next;
  logic                is_write;
  logic                fill;

  // tag compare across the indexed set
  always_comb begin
    hit_vec = '0;
    for (int w = 0; w < num_ways; w++) begin
      hit_vec[w] = valid_q[req.idx][w] && (tag_q[req.idx][w] == req.tag);
    end
  end

  // tags are unique within a set, so at most one bit is set
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < num_ways; w++) begin
      if (hit_vec[w]) begin
        hit_way = way_bits'(w);
      end
    end
  end

  assign hit      = |hit_vec;
  assign is_write = req_valid && (req.op == op_write);
  assign fill     = is_write && !hit;

  // hits touch their own way, fills take the way the tree names
  assign access_way = hit ? hit_way : victim_way;

  plru_tree #(
    .num_ways (num_ways)
  ) plru_i (
    .bits       (plru_q[req.idx]),
    .access_way (access_way),
    .victim_way (victim_way),
    .bits_next  (plru_next)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      rsp_valid <= 1'b0;
      vic_valid <= 1'b0;
      for (int s = 0; s < num_sets; s++) begin
        valid_q[s] <= '0;
        plru_q[s]  <= '0;
      end
    end else begin
      rsp_valid <= req_valid;
      // only a valid old line becomes a victim
      vic_valid <= fill && valid_q[req.idx][victim_way];
      // read miss leaves the tree alone
      if (req_valid && (hit || is_write)) begin
        plru_q[req.idx] <= plru_next;
      end
      if (is_write) begin
        valid_q[req.idx][access_way] <= 1'b1;
      end
    end
  end

  // response, victim capture and array writes
  always_ff @(posedge clock) begin
    rsp.hit  <= hit;
    rsp.data <= hit ? data_q[req.idx][hit_way] : '0;

    vic.idx        <= req.idx;
    vic.line.valid <= valid_q[req.idx][victim_way];
    vic.line.dirty <= dirty_q[req.idx][victim_way];
    vic.line.tag   <= tag_q[req.idx][victim_way];
    vic.line.data  <= data_q[req.idx][victim_way];

    // write hit keeps its tag, rewriting it is harmless
    if (is_write) begin
      tag_q[req.idx][access_way]   <= req.tag;
      data_q[req.idx][access_way]  <= req.data;
      dirty_q[req.idx][access_way] <= req.dirty;
    end
  end

endmodule

// File: source/plru_tree.sv
// plru_tree: tree pseudo-LRU for one set, picks the victim way and updates the node bits
`timescale 1ns/1ns

module plru_tree #(
  parameter int num_ways = 4
) (
  input  logic [num_ways-2:0]         bits,
  input  logic [$clog2(num_ways)-1:0] access_way,
  output logic [$clog2(num_ways)-1:0] victim_way,
  output logic [num_ways-2:0]         bits_next
);

  localparam int levels = $clog2(num_ways);

  // nodes in heap order, children of k at 2k+1 and 2k+2
  // a set bit steers the walk to the right half

  // walk from the root, one way bit per level, msb first
  always_comb begin
    int node;
    node = 0;
    victim_way = '0;
    for (int lvl = 0; lvl < levels; lvl++) begin
      victim_way[levels-1-lvl] = bits[node];
      node = 2 * node + 1 + int'(bits[node]);
    end
  end

  // every node on the accessed path points away from it
  always_comb begin
    int node;
    node = 0;
    bits_next = bits;
    for (int lvl = 0; lvl < levels; lvl++) begin
      // way in left half -> 1, right half -> 0
      bits_next[node] = ~access_way[levels-1-lvl];
      node = 2 * node + 1 + int'(access_way[levels-1-lvl]);
    end
  end

endmodule

// File: source/cache_pkg.sv
// cache_pkg: shared widths, request opcodes and packed transfer structs for the data cache
package cache_pkg;

  // geometry of the cache array
  localparam int num_sets  = 8;
  localparam int set_bits  = $clog2(num_sets);
  localparam int tag_bits  = 10;
  localparam int data_bits = 64;
  // full line address as seen by memory, tag above index
  localparam int addr_bits = tag_bits + set_bits;

  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } cache_op_t;

  // one request per cycle, writes and fills carry data and dirty
  typedef struct packed {
    cache_op_t            op;
    logic [set_bits-1:0]  idx;
    logic [tag_bits-1:0]  tag;
    logic [data_bits-1:0] data;
    logic                 dirty;
  } cache_req_t;

  typedef struct packed {
    logic                 valid;
    logic                 dirty;
    logic [tag_bits-1:0]  tag;
    logic [data_bits-1:0] data;
  } cache_line_t;

  typedef struct packed {
    logic                 hit;
    logic [data_bits-1:0] data;
  } cache_rsp_t;

  // evicted line plus the set it came from
  typedef struct packed {
    logic [set_bits-1:0] idx;
    cache_line_t         line;
  } victim_t;

  typedef struct packed {
    logic [addr_bits-1:0] addr;
    logic [data_bits-1:0] data;
  } wb_t;

endpackage
